// File: bdiPkg.sv
`default_nettype none

package bdiPkg;

    parameter int LineBits = 256;
    parameter int LineBytes = LineBits / 8;

    // Bit 0 is the low byte of word 0
    typedef logic [LineBits-1:0] line_t;

    // Declaration order is the selection priority
    typedef enum logic [2:0] {
        encB8D1,
        encB8D2,
        encB8D4,
        encB4D1,
        encB4D2,
        encB2D1,
        encRaw
    } encoding_t;

    typedef struct packed {
        encoding_t encoding;
        line_t     payload;
    } compLine_t;

    // Each flag covers every delta of the line
    typedef struct packed {
        logic fit1;
        logic fit2;
        logic fit4;
    } deltaFit_t;

    // Raw is treated as one word spanning the whole line
    function automatic int baseBytesOf(input encoding_t enc);
        case (enc)
            encB8D1, encB8D2, encB8D4:
                return 8;
            encB4D1, encB4D2:
                return 4;
            encB2D1:
                return 2;
            default:
                return LineBytes;
        endcase
    endfunction

    function automatic int deltaBytesOf(input encoding_t enc);
        case (enc)
            encB8D1, encB4D1, encB2D1:
                return 1;
            encB8D2, encB4D2:
                return 2;
            encB8D4:
                return 4;
            default:
                return 0;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: deltaFitCheck.sv
`timescale 1ns/1ns
`default_nettype none

module deltaFitCheck #(
    parameter int BaseBytes = 8
) (
    input  bdiPkg::line_t     lineIn,
    output bdiPkg::line_t     deltaLine,
    output bdiPkg::deltaFit_t fit
);

    localparam int WordBits = BaseBytes * 8;
    localparam int Words = bdiPkg::LineBits / WordBits;

    typedef logic [WordBits-1:0] word_t;

    word_t base;

    // Delta fits when it equals the sign extension of its low bytes
    function automatic logic fitsIn(input word_t delta, input int bytes);
        int    shift;
        word_t extended;
        if (bytes * 8 >= WordBits)
        begin
            return 1'b1;
        end
        shift = WordBits - bytes * 8;
        extended = word_t'($signed(delta << shift) >>> shift);
        return extended == delta;
    endfunction

    assign base = lineIn[WordBits-1:0];

    always_comb
    begin
        word_t delta;
        // Word 0 keeps the base
        deltaLine = lineIn;
        fit = '1;
        for (int w = 1; w < Words; w++)
        begin
            delta = lineIn[w*WordBits +: WordBits] - base;
            deltaLine[w*WordBits +: WordBits] = delta;
            fit.fit1 = fit.fit1 & fitsIn(delta, 1);
            fit.fit2 = fit.fit2 & fitsIn(delta, 2);
            fit.fit4 = fit.fit4 & fitsIn(delta, 4);
        end
    end

endmodule

`default_nettype wire

// File: compressPacker.sv
`timescale 1ns/1ns
`default_nettype none

module compressPacker (
    input  logic              clock,
    input  logic              arstN,
    input  bdiPkg::line_t     lineIn,
    input  logic              lineValid,
    input  bdiPkg::line_t     delta8,
    input  bdiPkg::line_t     delta4,
    input  bdiPkg::line_t     delta2,
    input  bdiPkg::deltaFit_t fit8,
    input  bdiPkg::deltaFit_t fit4,
    input  bdiPkg::deltaFit_t fit2,
    output bdiPkg::compLine_t compOut,
    output logic              compValid
);

    bdiPkg::encoding_t encoding;
    bdiPkg::line_t     payload;

    // Base in the low bytes, low bytes of each delta right above, zeros on top
    function automatic bdiPkg::line_t packDeltas(
        input bdiPkg::line_t     src,
        input bdiPkg::encoding_t enc
    );
        bdiPkg::line_t result;
        int            baseBytes;
        int            deltaBytes;
        int            wordIdx;
        int            lane;
        baseBytes = bdiPkg::baseBytesOf(enc);
        deltaBytes = bdiPkg::deltaBytesOf(enc);
        result = '0;
        for (int i = 0; i < bdiPkg::LineBytes; i++)
        begin
            wordIdx = i / baseBytes;
            lane = i % baseBytes;
            if (wordIdx == 0)
                result[i*8 +: 8] = src[i*8 +: 8];
            else if (lane < deltaBytes)
                result[(baseBytes + (wordIdx - 1) * deltaBytes + lane) * 8 +: 8] = src[i*8 +: 8];
        end
        return result;
    endfunction

    // First encoding that fits wins
    always_comb
    begin
        if (fit8.fit1)
            encoding = bdiPkg::encB8D1;
        else if (fit8.fit2)
            encoding = bdiPkg::encB8D2;
        else if (fit8.fit4)
            encoding = bdiPkg::encB8D4;
        else if (fit4.fit1)
            encoding = bdiPkg::encB4D1;
        else if (fit4.fit2)
            encoding = bdiPkg::encB4D2;
        else if (fit2.fit1)
            encoding = bdiPkg::encB2D1;
        else
            encoding = bdiPkg::encRaw;
    end

    always_comb
    begin
        case (encoding)
            bdiPkg::encB8D1: payload = packDeltas(delta8, bdiPkg::encB8D1);
            bdiPkg::encB8D2: payload = packDeltas(delta8, bdiPkg::encB8D2);
            bdiPkg::encB8D4: payload = packDeltas(delta8, bdiPkg::encB8D4);
            bdiPkg::encB4D1: payload = packDeltas(delta4, bdiPkg::encB4D1);
            bdiPkg::encB4D2: payload = packDeltas(delta4, bdiPkg::encB4D2);
            bdiPkg::encB2D1: payload = packDeltas(delta2, bdiPkg::encB2D1);
            default:         payload = lineIn;
        endcase
    end

    always_ff @(posedge clock or negedge arstN)
    begin
        if (!arstN)
        begin
            compOut <= '0;
            compValid <= 1'b0;
        end
        else
        begin
            compValid <= lineValid;
            if (lineValid)
            begin
                compOut.encoding <= encoding;
                compOut.payload <= payload;
            end
        end
    end

endmodule

`default_nettype wire

// File: lineExpander.sv
`timescale 1ns/1ns
`default_nettype none

module lineExpander (
    input  logic              clock,
    input  logic              arstN,
    input  bdiPkg::compLine_t compIn,
    input  logic              compValid,
    output bdiPkg::line_t     lineOut,
    output logic              expandValid
);

    bdiPkg::line_t rebuilt;

    // Word i is base plus sign-extended delta i, wrapped to the word width
    function automatic bdiPkg::line_t expandLine(
        input bdiPkg::line_t     payload,
        input bdiPkg::encoding_t enc
    );
        bdiPkg::line_t result;
        logic [63:0]   base;
        logic [63:0]   delta;
        logic [63:0]   sum;
        logic          sign;
        int            baseBytes;
        int            deltaBytes;
        int            slot;
        baseBytes = bdiPkg::baseBytesOf(enc);
        deltaBytes = bdiPkg::deltaBytesOf(enc);
        result = '0;
        base = '0;
        for (int j = 0; j < 8; j++)
        begin
            if (j < baseBytes)
                base[j*8 +: 8] = payload[j*8 +: 8];
        end
        for (int w = 0; w < 16; w++)
        begin
            if (w * baseBytes < bdiPkg::LineBytes)
            begin
                delta = '0;
                if (w > 0)
                begin
                    // First byte of this delta inside the payload
                    slot = baseBytes + (w - 1) * deltaBytes;
                    sign = payload[(slot + deltaBytes) * 8 - 1];
                    for (int j = 0; j < 8; j++)
                    begin
                        if (j < deltaBytes)
                            delta[j*8 +: 8] = payload[(slot + j) * 8 +: 8];
                        else
                            delta[j*8 +: 8] = {8{sign}};
                    end
                end
                sum = base + delta;
                for (int j = 0; j < 8; j++)
                begin
                    if (j < baseBytes)
                        result[(w * baseBytes + j) * 8 +: 8] = sum[j*8 +: 8];
                end
            end
        end
        return result;
    endfunction

    always_comb
    begin
        case (compIn.encoding)
            bdiPkg::encB8D1: rebuilt = expandLine(compIn.payload, bdiPkg::encB8D1);
            bdiPkg::encB8D2: rebuilt = expandLine(compIn.payload, bdiPkg::encB8D2);
            bdiPkg::encB8D4: rebuilt = expandLine(compIn.payload, bdiPkg::encB8D4);
            bdiPkg::encB4D1: rebuilt = expandLine(compIn.payload, bdiPkg::encB4D1);
            bdiPkg::encB4D2: rebuilt = expandLine(compIn.payload, bdiPkg::encB4D2);
            bdiPkg::encB2D1: rebuilt = expandLine(compIn.payload, bdiPkg::encB2D1);
            default:         rebuilt = compIn.payload;
        endcase
    end

    always_ff @(posedge clock or negedge arstN)
    begin
        if (!arstN)
        begin
            lineOut <= '0;
            expandValid <= 1'b0;
        end
        else
        begin
            expandValid <= compValid;
            if (compValid)
                lineOut <= rebuilt;
        end
    end

endmodule

`default_nettype wire

// File: bdiCodec.sv
`timescale 1ns/1ns
`default_nettype none

module bdiCodec (
    input  logic              clock,
    input  logic              arstN,
    input  bdiPkg::line_t     lineIn,
    input  logic              lineValid,
    output bdiPkg::compLine_t compOut,
    output logic              compValid,
    output bdiPkg::line_t     lineOut,
    output logic              expandValid
);

    bdiPkg::line_t     delta8;
    bdiPkg::line_t     delta4;
    bdiPkg::line_t     delta2;
    bdiPkg::deltaFit_t fit8;
    bdiPkg::deltaFit_t fit4;
    bdiPkg::deltaFit_t fit2;

    // One checker per base size
    deltaFitCheck #(.BaseBytes(8)) fit8Check (
        .lineIn   (lineIn),
        .deltaLine(delta8),
        .fit      (fit8)
    );

    deltaFitCheck #(.BaseBytes(4)) fit4Check (
        .lineIn   (lineIn),
        .deltaLine(delta4),
        .fit      (fit4)
    );

    deltaFitCheck #(.BaseBytes(2)) fit2Check (
        .lineIn   (lineIn),
        .deltaLine(delta2),
        .fit      (fit2)
    );

    compressPacker packer (
        .clock    (clock),
        .arstN    (arstN),
        .lineIn   (lineIn),
        .lineValid(lineValid),
        .delta8   (delta8),
        .delta4   (delta4),
        .delta2   (delta2),
        .fit8     (fit8),
        .fit4     (fit4),
        .fit2     (fit2),
        .compOut  (compOut),
        .compValid(compValid)
    );

    lineExpander expander (
        .clock      (clock),
        .arstN      (arstN),
        .compIn     (compOut),
        .compValid  (compValid),
        .lineOut    (lineOut),
        .expandValid(expandValid)
    );

endmodule

`default_nettype wire

// File: bdiChecker.sv
`timescale 1ns/1ns
`default_nettype none

module bdiChecker (
    input logic              clock,
    input logic              arstN,
    input bdiPkg::line_t     lineIn,
    input logic              lineValid,
    input logic              boundary,
    input bdiPkg::compLine_t compOut,
    input logic              compValid,
    input bdiPkg::line_t     lineOut,
    input logic              expandValid
);

    typedef struct packed {
        logic          boundary;
        bdiPkg::line_t line;
    } entry_t;

    entry_t            compQueue[$];
    entry_t            expandQueue[$];
    entry_t            head;
    bdiPkg::compLine_t model;
    logic              started = 1'b0;
    logic              validD1 = 1'b0;
    logic              validD2 = 1'b0;
    int                checks[6];
    int                errors[6];

    function automatic string testName(input int test);
        case (test)
            0: return "encodingChoice";
            1: return "payloadLayout";
            2: return "roundTrip";
            3: return "latency";
            4: return "resetQuiet";
            default: return "boundaryDeltas";
        endcase
    endfunction

    // Priority index to base and delta bytes
    function automatic void shapeOf(input int idx, output int b, output int k);
        b = (idx < 3) ? 8 : (idx < 5) ? 4 : 2;
        k = (idx == 2) ? 4 : (idx == 1 || idx == 4) ? 2 : 1;
    endfunction

    function automatic logic [63:0] wordAt(input bdiPkg::line_t line, input int b, input int w);
        logic [63:0] value;
        value = '0;
        for (int j = 0; j < b; j++)
            value[j*8 +: 8] = line[(w * b + j) * 8 +: 8];
        return value;
    endfunction

    // Signed delta must lie in [-limit, limit)
    function automatic logic deltasFit(input bdiPkg::line_t line, input int b, input int k);
        logic [63:0] diff;
        longint      value;
        longint      limit;
        limit = longint'(1) << (8 * k - 1);
        for (int w = 1; w < 32 / b; w++)
        begin
            diff = (wordAt(line, b, w) - wordAt(line, b, 0)) << (64 - 8 * b);
            value = $signed(diff) >>> (64 - 8 * b);
            if (value < -limit || value >= limit)
                return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic bdiPkg::compLine_t modelRecord(input bdiPkg::line_t line);
        bdiPkg::compLine_t rec;
        logic [63:0]       diff;
        int                b;
        int                k;
        int                pos;
        rec.encoding = bdiPkg::encRaw;
        rec.payload = line;
        // Walk backwards so the highest priority fit is kept
        for (int idx = 5; idx >= 0; idx--)
        begin
            shapeOf(idx, b, k);
            if (deltasFit(line, b, k))
                rec.encoding = bdiPkg::encoding_t'(idx);
        end
        if (rec.encoding != bdiPkg::encRaw)
        begin
            shapeOf(int'(rec.encoding), b, k);
            rec.payload = '0;
            rec.payload[63:0] = wordAt(line, b, 0);
            pos = b;
            for (int w = 1; w < 32 / b; w++)
            begin
                diff = wordAt(line, b, w) - wordAt(line, b, 0);
                for (int j = 0; j < k; j++)
                    rec.payload[(pos + j) * 8 +: 8] = diff[j*8 +: 8];
                pos += k;
            end
        end
        return rec;
    endfunction

    task automatic check(input int test, input logic [258:0] expected,
                         input logic [258:0] actual);
        checks[test]++;
        if (expected !== actual)
        begin
            errors[test]++;
            $display("Mismatch %s expected %h actual %h", testName(test), expected, actual);
        end
    endtask

    // Outputs and inputs are both settled at the falling edge
    always @(negedge clock)
    begin
        if (!arstN || !started)
            check(4, 2'b00, {compValid, expandValid});
        else
            check(3, {validD1, validD2}, {compValid, expandValid});
        if (arstN && expandValid)
        begin
            if (expandQueue.size() == 0)
            begin
                errors[2]++;
                $display("expandValid was high with no line in flight");
            end
            else
            begin
                head = expandQueue.pop_front();
                check(2, head.line, lineOut);
            end
        end
        if (arstN && compValid)
        begin
            if (compQueue.size() == 0)
            begin
                errors[0]++;
                $display("compValid was high with no line in flight");
            end
            else
            begin
                head = compQueue.pop_front();
                model = modelRecord(head.line);
                check(head.boundary ? 5 : 0, model.encoding, compOut.encoding);
                check(head.boundary ? 5 : 1, model.payload, compOut.payload);
                expandQueue.push_back(head);
            end
        end
        validD2 = arstN & validD1;
        validD1 = arstN & lineValid;
        if (arstN && lineValid)
        begin
            started = 1'b1;
            compQueue.push_back({boundary, lineIn});
        end
    end

    task automatic report(output int failures);
        int total;
        failures = 0;
        total = 0;
        if (compQueue.size() + expandQueue.size() != 0)
        begin
            errors[3]++;
            $display("Lines still in flight at the end of the run");
        end
        for (int t = 0; t < 6; t++)
        begin
            $display("%s: %0d checks, %0d errors", testName(t), checks[t], errors[t]);
            total += checks[t];
            failures += errors[t];
        end
        $display("Total: %0d checks, %0d errors", total, failures);
    endtask

endmodule

`default_nettype wire

// File: bdiCodec_tb.sv
`timescale 1ns/1ns
`default_nettype none

module bdiCodec_tb;

    localparam int NumLines = 600;
    localparam int BoundaryLines = 18;
    localparam int ResetCycles = 10;
    // At most three cycles per line, plus reset and drain
    localparam int CycleLimit = (NumLines + BoundaryLines) * 4 + ResetCycles + 50;

    logic              clock = 1'b0;
    logic              arstN;
    bdiPkg::line_t     lineIn;
    logic              lineValid;
    logic              boundary;
    bdiPkg::compLine_t compOut;
    logic              compValid;
    bdiPkg::line_t     lineOut;
    logic              expandValid;
    bdiPkg::line_t     line;
    integer            seed = 5612;
    int                cycles = 0;
    int                failures;

    always #2 clock = ~clock;

    bdiCodec uut (
        .clock      (clock),
        .arstN      (arstN),
        .lineIn     (lineIn),
        .lineValid  (lineValid),
        .compOut    (compOut),
        .compValid  (compValid),
        .lineOut    (lineOut),
        .expandValid(expandValid)
    );

    bdiChecker scoreboard (
        .clock      (clock),
        .arstN      (arstN),
        .lineIn     (lineIn),
        .lineValid  (lineValid),
        .boundary   (boundary),
        .compOut    (compOut),
        .compValid  (compValid),
        .lineOut    (lineOut),
        .expandValid(expandValid)
    );

    // Target 6 is raw; kind 0 to 2 put words 1 and 2 at or just past the limits
    task automatic makeLine(input int target, input int kind);
        logic [63:0] base;
        logic [63:0] delta;
        logic [63:0] word;
        logic [63:0] limit;
        int          b;
        int          k;
        b = (target < 3) ? 8 : (target < 5) ? 4 : 2;
        k = (target == 2) ? 4 : (target == 1 || target == 4) ? 2 : 1;
        limit = 64'd1 << (8 * k - 1);
        base = {$random(seed), $random(seed)};
        line = '0;
        for (int w = 0; w < 32 / b; w++)
        begin
            delta = {$random(seed), $random(seed)};
            if (target < 6)
            begin
                if (w == 0)
                    delta = '0;
                else
                    delta = $signed(delta << (64 - 8 * k)) >>> (64 - 8 * k);
            end
            if (kind >= 0)
            begin
                case (w)
                    1: delta = (kind == 1) ? limit : limit - 1;
                    2: delta = (kind == 2) ? -limit - 1 : -limit;
                    default: delta = '0;
                endcase
            end
            word = base + delta;
            for (int j = 0; j < b; j++)
                line[(w * b + j) * 8 +: 8] = word[j*8 +: 8];
        end
    endtask

    task automatic driveLine(input logic isBoundary);
        lineIn = line;
        lineValid = 1'b1;
        boundary = isBoundary;
        @(posedge clock);
        #1;
        lineValid = 1'b0;
        // Occasional gap of one or two idle cycles
        if (($random(seed) & 3) == 0)
        begin
            repeat (1 + ($random(seed) & 1))
            begin
                @(posedge clock);
                #1;
            end
        end
    endtask

    initial
    begin
        arstN = 1'b0;
        lineIn = '0;
        lineValid = 1'b0;
        boundary = 1'b0;
        repeat (ResetCycles) @(posedge clock);
        #1;
        arstN = 1'b1;
        repeat (3) @(posedge clock);
        #1;
        for (int n = 0; n < NumLines; n++)
        begin
            makeLine($unsigned($random(seed)) % 7, -1);
            driveLine(1'b0);
        end
        for (int t = 0; t < 6; t++)
        begin
            for (int kind = 0; kind < 3; kind++)
            begin
                makeLine(t, kind);
                driveLine(1'b1);
            end
        end
        repeat (4) @(negedge clock);
        scoreboard.report(failures);
        if (failures == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    always @(posedge clock)
    begin
        cycles <= cycles + 1;
        if (cycles >= CycleLimit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
            $display("Checks failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: bdiCodec.f
bdiPkg.sv
deltaFitCheck.sv
compressPacker.sv
lineExpander.sv
bdiCodec.sv
bdiChecker.sv
bdiCodec_tb.sv

// File: Bender.yml
package:
  name: bdiCodec

sources:
  - bdiPkg.sv
  - deltaFitCheck.sv
  - compressPacker.sv
  - lineExpander.sv
  - bdiCodec.sv
  - target: simulation
    files:
      - bdiChecker.sv
      - bdiCodec_tb.sv
